// File: hdl/board_pkg.sv
// Board constants package
`default_nettype none

package board_pkg;

    // ----------------------------------------
    // Board clock and I/O widths
    // ----------------------------------------

    localparam int clk_mhz     = 50;             // Board oscillator
    localparam int w_key       = 3;              // Lab keys, reset key excluded
    localparam int w_sw        = 8;
    localparam int w_led       = 12;
    localparam int w_digit     = 8;              // Physical digits
    localparam int w_lab_digit = w_digit - 1;    // Rightmost digit is dead

    // ----------------------------------------
    // Audio sample widths and I2S framing
    // ----------------------------------------

    localparam int w_mic         = 24;           // INMP441 sample
    localparam int w_sound       = 16;           // DAC sample
    localparam int i2s_bclk_div  = 8;            // Clocks per half bit clock
    localparam int i2s_slot_bits = 32;           // Bit clocks per channel slot

    // ----------------------------------------
    // Lab timing
    // ----------------------------------------

    localparam int tone_half_period = 4096;      // Square wave half period
    localparam int scan_cycles      = 64;        // Clocks per lit digit

    // One tick per second at the board clock
    localparam int slow_tick_cycles_default = clk_mhz * 1000000;

endpackage

`default_nettype wire

// File: hdl/slow_tick_gen.sv
// Slow tick strobe generator
`timescale 1ns/1ps
`default_nettype none

module slow_tick_gen #(
    parameter int tick_cycles = board_pkg::slow_tick_cycles_default
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int w_cnt = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;

    logic [w_cnt-1:0] cnt;                        // Cycles since last tick
    logic             wrap;                       // Last cycle of period

    assign wrap = (cnt == w_cnt'(tick_cycles - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (wrap) begin
            cnt  <= '0;                           // Start next period
            tick <= 1'b1;                         // Single cycle strobe
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2s_mic_receiver.sv
// INMP441 microphone receiver
`timescale 1ns/1ps
`default_nettype none

module i2s_mic_receiver (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        sck,
    output logic                        ws,
    input  logic                        sd,
    output logic [board_pkg::w_mic-1:0] mic_value,
    output logic                        mic_valid
);

    import board_pkg::*;

    localparam int w_div = $clog2(i2s_bclk_div);
    localparam int w_bit = $clog2(2 * i2s_slot_bits);

    logic [w_div-1:0] div_cnt;                    // Half bit clock divider
    logic [w_bit-1:0] bit_cnt;                    // Bit clock index in frame
    logic [w_mic-1:0] shift;                      // Incoming sample, MSB first
    logic             half_done;
    logic             sck_rise;
    logic             sck_fall;
    logic             data_bit;                   // Left slot payload bit

    // ----------------------------------------
    // Bit clock and word select
    // ----------------------------------------

    assign half_done = (div_cnt == w_div'(i2s_bclk_div - 1));
    assign sck_rise  = half_done & ~sck;          // sck about to go high
    assign sck_fall  = half_done &  sck;          // sck about to go low

    assign ws = bit_cnt[w_bit-1];                 // Low for left slot

    // Bit 0 is the I2S delay bit, then 24 data bits
    assign data_bit = ~ws
                   && (bit_cnt >= w_bit'(1))
                   && (bit_cnt <= w_bit'(w_mic));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end else begin
            div_cnt <= half_done ? '0 : div_cnt + 1'b1;
            if (half_done)
                sck <= ~sck;
            if (sck_fall) begin
                if (bit_cnt == w_bit'(2 * i2s_slot_bits - 1))
                    bit_cnt <= '0;                // New frame, left slot
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Capture and publish
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (sck_rise && data_bit)
            shift <= {shift[w_mic-2:0], sd};      // Mic drives sd on falling sck
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mic_value <= '0;
            mic_valid <= 1'b0;
        end else begin
            mic_valid <= 1'b0;
            if (sck_fall && bit_cnt == w_bit'(i2s_slot_bits - 1)) begin
                mic_value <= shift;               // Held until next frame
                mic_valid <= 1'b1;                // End of left slot
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2s_audio_out.sv
// I2S audio DAC transmitter
`timescale 1ns/1ps
`default_nettype none

module i2s_audio_out (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [board_pkg::w_sound-1:0] sound,
    output logic                          mclk,
    output logic                          bclk,
    output logic                          lrclk,
    output logic                          sdata
);

    import board_pkg::*;

    localparam int w_div  = $clog2(i2s_bclk_div);
    localparam int w_bit  = $clog2(2 * i2s_slot_bits);
    localparam int w_slot = w_bit - 1;

    logic [w_div-1:0]   div_cnt;                  // Half bit clock divider
    logic [w_bit-1:0]   bit_cnt;                  // Bit clock index in frame
    logic [w_bit-1:0]   bit_nxt;
    logic [w_slot-1:0]  slot_nxt;                 // Index inside channel slot
    logic [w_sound-1:0] sample;                   // Frame sample for right slot
    logic [w_sound-1:0] shift;                    // Outgoing bits, MSB first
    logic               half_done;
    logic               bclk_fall;

    assign half_done = (div_cnt == w_div'(i2s_bclk_div - 1));
    assign bclk_fall = half_done & bclk;

    assign bit_nxt  = (bit_cnt == w_bit'(2 * i2s_slot_bits - 1)) ? '0 : bit_cnt + 1'b1;
    assign slot_nxt = bit_nxt[w_slot-1:0];

    // ----------------------------------------
    // Master and bit clocks
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            mclk    <= 1'b0;
            div_cnt <= '0;
            bclk    <= 1'b0;
        end else begin
            mclk    <= ~mclk;                     // clk / 2
            div_cnt <= half_done ? '0 : div_cnt + 1'b1;
            if (half_done)
                bclk <= ~bclk;
        end
    end

    // ----------------------------------------
    // Frame counter and serializer
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt <= '0;
            lrclk   <= 1'b0;
            sdata   <= 1'b0;
            sample  <= '0;
            shift   <= '0;
        end else if (bclk_fall) begin
            bit_cnt <= bit_nxt;
            lrclk   <= bit_nxt[w_bit-1];          // Changes while bclk goes low
            if (bit_nxt == '0)
                sample <= sound;                  // Latch at lrclk fall
            if (slot_nxt == '0) begin
                // Slot start, delay bit goes out first
                shift <= (bit_nxt == '0) ? sound : sample;
                sdata <= 1'b0;
            end else begin
                sdata <= shift[w_sound-1];        // Zero padded after LSB
                shift <= {shift[w_sound-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/seven_seg_display.sv
// Seven segment scan display
`timescale 1ns/1ps
`default_nettype none

module seven_seg_display (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [board_pkg::w_lab_digit*4-1:0] value,
    input  logic [board_pkg::w_lab_digit-1:0]   blank,
    output logic [7:0]                          abcdefgh,
    output logic [board_pkg::w_lab_digit-1:0]   digit
);

    import board_pkg::*;

    localparam int w_scan = $clog2(scan_cycles);
    localparam int w_idx  = $clog2(w_lab_digit);

    logic [w_scan-1:0] scan_cnt;                  // Clocks on current digit
    logic [w_idx-1:0]  idx;                       // Active digit number
    logic              step;
    logic              wrap;
    logic [3:0]        nibble;

    // ----------------------------------------
    // Digit scan
    // ----------------------------------------

    assign step = (scan_cnt == w_scan'(scan_cycles - 1));

    // Restart from digit 0 after reset or the last digit
    assign wrap = (digit == '0) || (idx == w_idx'(w_lab_digit - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt <= '0;
            idx      <= '0;
            digit    <= '0;                       // All off until first step
        end else begin
            scan_cnt <= step ? '0 : scan_cnt + 1'b1;
            if (step) begin
                if (wrap) begin
                    idx   <= '0;
                    digit <= w_lab_digit'(1);
                end else begin
                    idx   <= idx + 1'b1;
                    digit <= digit << 1;          // One hot, round robin
                end
            end
        end
    end

    // ----------------------------------------
    // Hex decoder, segments a..g then dot
    // ----------------------------------------

    assign nibble = value[idx*4 +: 4];

    always_comb begin
        case (nibble)
            4'h0: abcdefgh = 8'b1111_1100;
            4'h1: abcdefgh = 8'b0110_0000;
            4'h2: abcdefgh = 8'b1101_1010;
            4'h3: abcdefgh = 8'b1111_0010;
            4'h4: abcdefgh = 8'b0110_0110;
            4'h5: abcdefgh = 8'b1011_0110;
            4'h6: abcdefgh = 8'b1011_1110;
            4'h7: abcdefgh = 8'b1110_0000;
            4'h8: abcdefgh = 8'b1111_1110;
            4'h9: abcdefgh = 8'b1111_0110;
            4'ha: abcdefgh = 8'b1110_1110;
            4'hb: abcdefgh = 8'b0011_1110;
            4'hc: abcdefgh = 8'b1001_1100;
            4'hd: abcdefgh = 8'b0111_1010;
            4'he: abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;     // F
        endcase
        if (blank[idx])
            abcdefgh = 8'b0000_0000;              // Blanked digit stays dark
    end

endmodule

`default_nettype wire

// File: hdl/lab_top.sv
// Example lab logic
`timescale 1ns/1ps
`default_nettype none

module lab_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              tick,
    input  logic [board_pkg::w_key-1:0]       key,
    input  logic [board_pkg::w_sw-1:0]        sw,
    input  logic [board_pkg::w_mic-1:0]       mic_value,
    input  logic                              mic_valid,
    output logic [board_pkg::w_led-1:0]       led,
    output logic [7:0]                        abcdefgh,
    output logic [board_pkg::w_lab_digit-1:0] digit,
    output logic [board_pkg::w_sound-1:0]     sound
);

    import board_pkg::*;

    localparam int w_tone = $clog2(tone_half_period);

    logic [15:0]                count;            // Four hex digits
    logic [7:0]                 mic_byte;         // Top byte of last sample
    logic [w_tone-1:0]          tone_cnt;
    logic                       tone_phase;       // High for negative half
    logic                       tone_end;
    logic [w_sound-1:0]         tone_level;
    logic [w_lab_digit*4-1:0]   disp_value;
    logic [w_lab_digit-1:0]     disp_blank;

    // ----------------------------------------
    // LEDs and counter
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset)
            led <= '0;
        else
            led <= {key[2], {(w_led - w_sw - 1){1'b0}}, sw};  // Tone gate and switches
    end

    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (key[1])
            count <= '0;                          // Clear wins over count
        else if (key[0] && tick)
            count <= count + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset)
            mic_byte <= '0;
        else if (mic_valid)
            mic_byte <= mic_value[w_mic-1 -: 8];
    end

    // ----------------------------------------
    // Square wave tone
    // ----------------------------------------

    assign tone_end   = (tone_cnt == w_tone'(tone_half_period - 1));
    assign tone_level = {sw, {(w_sound - w_sw){1'b0}}};  // Amplitude from switches

    always_ff @(posedge clk) begin
        if (reset) begin
            tone_cnt   <= '0;
            tone_phase <= 1'b0;
            sound      <= '0;
        end else begin
            tone_cnt <= tone_end ? '0 : tone_cnt + 1'b1;
            if (tone_end)
                tone_phase <= ~tone_phase;
            if (!key[2])
                sound <= '0;                      // Silent when released
            else if (tone_phase)
                sound <= -tone_level;
            else
                sound <= tone_level;
        end
    end

    // ----------------------------------------
    // Display content
    // ----------------------------------------

    // Top digit unused, then mic byte, then counter
    assign disp_value = {{(w_lab_digit*4 - 24){1'b0}}, mic_byte, count};
    assign disp_blank = {1'b1, {(w_lab_digit - 1){1'b0}}};

    seven_seg_display u_seven_seg_display (
        .clk      (clk),
        .reset    (reset),
        .value    (disp_value),
        .blank    (disp_blank),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

`default_nettype wire

// File: hdl/board_top.sv
// Board level wrapper
`timescale 1ns/1ps
`default_nettype none

module board_top #(
    parameter int tick_cycles = board_pkg::slow_tick_cycles_default
) (
    input  logic                          clk,
    input  logic [board_pkg::w_key:0]     key_n,      // Top key is reset
    input  logic [board_pkg::w_sw-1:0]    sw_n,
    output logic [board_pkg::w_led-1:0]   led_n,
    output logic [7:0]                    abcdefgh_n,
    output logic [board_pkg::w_digit-1:0] digit_n,
    output logic                          mic_sck,
    output logic                          mic_ws,
    output logic                          mic_lr,
    input  logic                          mic_sd,
    output logic                          dac_mclk,
    output logic                          dac_bclk,
    output logic                          dac_lrclk,
    output logic                          dac_sdata
);

    import board_pkg::*;

    logic                   reset;
    logic                   tick;
    logic [w_mic-1:0]       mic_value;
    logic                   mic_valid;
    logic [w_sound-1:0]     sound;
    logic [w_led-1:0]       led;
    logic [7:0]             abcdefgh;
    logic [w_lab_digit-1:0] lab_digit;

    // ----------------------------------------
    // Reset and polarity
    // ----------------------------------------

    always_ff @(posedge clk) begin
        reset <= ~key_n[w_key];                   // Key press gives reset
    end

    assign led_n      = ~led;
    assign abcdefgh_n = ~abcdefgh;
    assign digit_n    = ~{lab_digit, 1'b0};       // Dead right digit kept off
    assign mic_lr     = 1'b0;                     // Mic on left channel

    // ----------------------------------------
    // Blocks
    // ----------------------------------------

    slow_tick_gen #(.tick_cycles(tick_cycles)) u_slow_tick_gen (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    i2s_mic_receiver u_i2s_mic_receiver (
        .clk       (clk),
        .reset     (reset),
        .sck       (mic_sck),
        .ws        (mic_ws),
        .sd        (mic_sd),
        .mic_value (mic_value),
        .mic_valid (mic_valid)
    );

    lab_top u_lab_top (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .key       (~key_n[w_key-1:0]),
        .sw        (~sw_n),
        .mic_value (mic_value),
        .mic_valid (mic_valid),
        .led       (led),
        .abcdefgh  (abcdefgh),
        .digit     (lab_digit),               // Lab digits only
        .sound     (sound)
    );

    i2s_audio_out u_i2s_audio_out (
        .clk   (clk),
        .reset (reset),
        .sound (sound),
        .mclk  (dac_mclk),
        .bclk  (dac_bclk),
        .lrclk (dac_lrclk),
        .sdata (dac_sdata)
    );

endmodule

`default_nettype wire

// File: verif/board_top_properties.sv
// Board output assertions
`timescale 1ns/1ps
`default_nettype none

module board_top_properties (
    input logic                          clk,
    input logic                          reset,
    input logic [board_pkg::w_digit-1:0] digit_n,
    input logic                          dac_bclk,
    input logic                          dac_lrclk
);

    import board_pkg::*;

    int fail_count = 0;                           // Failed assertions so far

    // ----------------------------------------
    // Display digits
    // ----------------------------------------

    dead_digit_off: assert property (
        @(posedge clk) disable iff (reset !== 1'b0) digit_n[0]
    ) else begin
        $error("dead digit digit_n[0] went low");
        fail_count++;
    end

    one_digit_lit: assert property (
        @(posedge clk) disable iff (reset !== 1'b0) $onehot0(~digit_n[w_digit-1:1])
    ) else begin
        $error("more than one lab digit active, digit_n %h", digit_n);
        fail_count++;
    end

    // ----------------------------------------
    // DAC framing
    // ----------------------------------------

    lrclk_on_low_bclk: assert property (
        @(posedge clk) disable iff (reset !== 1'b0)
        (dac_lrclk != $past(dac_lrclk)) |-> !dac_bclk
    ) else begin
        $error("dac_lrclk changed while dac_bclk high");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: verif/tb_board_top.sv
// Board wrapper testbench
`timescale 1ns/1ps
`default_nettype none

module tb_board_top;

    import board_pkg::*;

    localparam int clk_period   = 20;
    localparam int tick_cycles  = 16;                              // Short ticks for simulation
    localparam int frame_cycles = 2 * i2s_slot_bits * 2 * i2s_bclk_div;
    localparam int scan_period  = w_lab_digit * scan_cycles;       // One full round of digits
    localparam int num_tests    = 5;
    localparam int test_frames  = 40;                              // Worst case per test
    localparam int test_scans   = 16;
    localparam int watchdog_ns  =
        num_tests * (test_frames * frame_cycles + test_scans * scan_period) * clk_period;

    // Segments a..g, a in the top bit
    localparam logic [6:0] hex_segs [16] = '{
        7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
        7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47
    };

    logic               clk;
    logic [w_key:0]     key_n;
    logic [w_sw-1:0]    sw_n;
    logic [w_led-1:0]   led_n;
    logic [7:0]         abcdefgh_n;
    logic [w_digit-1:0] digit_n;
    logic               mic_sck;
    logic               mic_ws;
    logic               mic_lr;
    logic               dac_mclk;
    logic               dac_bclk;
    logic               dac_lrclk;
    logic               dac_sdata;

    int                 error_count;
    int                 check_count;
    logic               mic_sd      = 1'b0;
    logic [w_mic-1:0]   mic_word    = '0;                          // Word the mic sends
    logic [w_mic-1:0]   mic_frame   = '0;                          // Latched at slot start
    int                 mic_bit     = 0;
    logic               mic_ws_prev = 1'b0;
    logic [4:0]         shown [w_lab_digit] = '{default: 5'h10};   // 5'h10 means dark
    logic [w_sound-1:0] dac_samples [$];
    logic [w_sound-1:0] dac_shift   = '0;
    int                 dac_pos     = 0;
    logic               dac_lr_prev = 1'b0;
    logic               dac_synced  = 1'b0;

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    board_top #(.tick_cycles(tick_cycles)) u_board_top (
        .clk        (clk),
        .key_n      (key_n),
        .sw_n       (sw_n),
        .led_n      (led_n),
        .abcdefgh_n (abcdefgh_n),
        .digit_n    (digit_n),
        .mic_sck    (mic_sck),
        .mic_ws     (mic_ws),
        .mic_lr     (mic_lr),
        .mic_sd     (mic_sd),
        .dac_mclk   (dac_mclk),
        .dac_bclk   (dac_bclk),
        .dac_lrclk  (dac_lrclk),
        .dac_sdata  (dac_sdata)
    );

    bind board_top board_top_properties u_board_top_properties (
        .clk       (clk),
        .reset     (reset),
        .digit_n   (digit_n),
        .dac_bclk  (dac_bclk),
        .dac_lrclk (dac_lrclk)
    );

    // ----------------------------------------
    // Bus models and monitors
    // ----------------------------------------

    // INMP441, delay bit after ws fall then MSB first
    always @(negedge mic_sck) begin
        #1;                                                        // ws settles with sck
        if (mic_ws_prev && !mic_ws) begin
            mic_bit   = 0;
            mic_frame = mic_word;
        end else begin
            mic_bit = mic_bit + 1;
        end
        mic_ws_prev = mic_ws;
        if (!mic_ws && mic_bit >= 1 && mic_bit <= w_mic)
            mic_sd = mic_frame[w_mic - mic_bit];
        else
            mic_sd = 1'b0;                                         // Tristate on a real mic
    end

    // I2S deserializer, one sample per slot
    always @(posedge dac_bclk) begin
        if (dac_lrclk != dac_lr_prev) begin
            dac_pos    = 0;                                        // Delay bit
            dac_synced = 1'b1;
        end else begin
            dac_pos = dac_pos + 1;
        end
        dac_lr_prev = dac_lrclk;
        if (dac_pos >= 1 && dac_pos <= w_sound) begin
            dac_shift = {dac_shift[w_sound-2:0], dac_sdata};
            if (dac_pos == w_sound && dac_synced)
                dac_samples.push_back(dac_shift);
        end
    end

    // Segment monitor, outputs are stable mid cycle
    always @(negedge clk) begin
        for (int i = 0; i < w_lab_digit; i++)
            if (!digit_n[i + 1])
                shown[i] = seg_nibble(~abcdefgh_n);
    end

    function automatic logic [4:0] seg_nibble(input logic [7:0] seg);
        logic [4:0] result;
        result = 5'h10;
        for (int i = 0; i < 16; i++)
            if (seg == {hex_segs[i], 1'b0})
                result = 5'(i);
        return result;
    endfunction

    function automatic logic shows(input int lo, input int n, input logic [15:0] value);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < n; i++)
            if (shown[lo + i] != {1'b0, value[i*4 +: 4]})
                ok = 1'b0;
        return ok;
    endfunction

    function automatic logic [15:0] shown_bits(input int lo, input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
            bits[i*4 +: 4] = shown[lo + i][3:0];
        return bits;
    endfunction

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;                                                        // Drive after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected)
        else begin
            error_count++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic wait_display(input int lo, input int n, input logic [15:0] value,
                                input int limit, input string what);
        int waited;
        waited = 0;
        while (!shows(lo, n, value) && waited < limit) begin
            step(1);
            waited++;
        end
        check_value(what, 32'(shown_bits(lo, n)), 32'(value));
    endtask

    task automatic wait_samples(input int count);
        int waited;
        waited = 0;
        while (dac_samples.size() < count && waited < (count / 2 + 2) * frame_cycles) begin
            step(1);
            waited++;
        end
        check_count++;
        assert (dac_samples.size() >= count)
        else begin
            error_count++;
            $display("Error: only %0d of %0d DAC samples arrived in time",
                     dac_samples.size(), count);
        end
    endtask

    task automatic hold_key(input int k, input int cycles);
        key_n[k] = 1'b0;
        step(cycles);
        key_n[k] = 1'b1;
    endtask

    task automatic print_counts();
        $display("Checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
                 u_board_top.u_board_top_properties.fail_count);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic test_reset();
        logic mclk_prev;
        check_value("led_n", 32'(led_n), 32'(12'hfff));
        check_value("digit_n", 32'(digit_n), 32'(8'hff));          // Dark until first step
        check_value("dac_lrclk", 32'(dac_lrclk), 32'h0);
        check_value("dac_sdata", 32'(dac_sdata), 32'h0);
        check_value("mic_lr", 32'(mic_lr), 32'h0);                 // Mic on left slot
        mclk_prev = dac_mclk;
        repeat (4) begin
            step(1);
            check_value("dac_mclk", 32'(dac_mclk), 32'(!mclk_prev));  // clk / 2
            mclk_prev = dac_mclk;
        end
    endtask

    task automatic test_switches();
        logic [w_sw-1:0] sw;
        logic [w_sw-1:0] led_exp;
        int              waited;
        int              lit;
        repeat (4) begin
            sw      = w_sw'($urandom);
            sw_n    = ~sw;
            led_exp = ~sw;                                         // Lit for set switches
            waited  = 0;
            while (led_n[w_sw-1:0] !== led_exp && waited < 8) begin
                step(1);
                waited++;
            end
            check_value("led_n[7:0]", 32'(led_n[w_sw-1:0]), 32'(led_exp));
            check_value("led_n[11]", 32'(led_n[w_led-1]), 32'h1);  // Tone gate off
        end
        lit = 0;
        for (int c = 0; c < scan_period; c++) begin
            if (digit_n[0] !== 1'b1)
                lit++;
            step(1);
        end
        check_value("digit_n[0] low cycles", 32'(lit), 32'h0);
    endtask

    // A window of n*tick_cycles held clocks holds exactly n ticks
    task automatic test_counter();
        int n1;
        int n2;
        n1 = int'($urandom_range(3, 20));
        n2 = int'($urandom_range(1, 20));
        hold_key(0, n1 * tick_cycles);
        wait_display(0, 4, 16'(n1), 2 * scan_period, "count digits");
        hold_key(0, n2 * tick_cycles);
        wait_display(0, 4, 16'(n1 + n2), 2 * scan_period, "count digits");
        hold_key(1, 2);
        wait_display(0, 4, 16'h0000, 2 * scan_period, "count digits after clear");
    endtask

    task automatic test_mic();
        logic [7:0] top;
        top = mic_word[w_mic-1 -: 8];
        repeat (4) begin
            top      = top + 8'($urandom_range(1, 255));             // New top byte each time
            mic_word = {top, 16'($urandom)};
            wait_display(4, 2, 16'(top), 2 * frame_cycles + 2 * scan_period, "mic digits");
        end
    endtask

    task automatic test_tone();
        logic [w_sw-1:0]    sw;
        logic [w_sound-1:0] pos;
        logic [w_sound-1:0] neg;
        int                 n_pos;
        int                 n_neg;
        sw = 8'h00;
        while (sw == 8'h00 || sw == 8'h80)
            sw = w_sw'($urandom);                                  // Both halves must differ
        pos      = {sw, 8'h00};
        neg      = ~pos + 1'b1;
        n_pos    = 0;
        n_neg    = 0;
        sw_n     = ~sw;
        key_n[2] = 1'b0;
        dac_samples.delete();
        wait_samples(4);                                           // Frames latched before the key
        dac_samples.delete();
        wait_samples(32);                                          // Two tone periods
        check_value("led_n[11]", 32'(led_n[w_led-1]), 32'h0);
        foreach (dac_samples[i]) begin
            if (dac_samples[i] == pos)
                n_pos++;
            else if (dac_samples[i] == neg)
                n_neg++;
            else
                check_value("dac sample", 32'(dac_samples[i]), 32'(pos));
        end
        check_count++;
        assert (n_pos > 0 && n_neg > 0)
        else begin
            error_count++;
            $display("Error: tone missed a polarity, %0d positive and %0d negative samples",
                     n_pos, n_neg);
        end
        key_n[2] = 1'b1;
        dac_samples.delete();
        wait_samples(4);
        dac_samples.delete();
        wait_samples(8);
        foreach (dac_samples[i])
            check_value("dac sample", 32'(dac_samples[i]), 32'h0);  // Silent
    endtask

    // ----------------------------------------
    // Sequence and watchdog
    // ----------------------------------------

    initial begin
        void'($urandom(47920));
        error_count = 0;
        check_count = 0;
        key_n       = {1'b0, {w_key{1'b1}}};                       // Reset key pressed
        sw_n        = '1;
        step(2);
        key_n[w_key] = 1'b1;
        step(1);
        test_reset();
        test_switches();
        test_counter();
        test_mic();
        test_tone();
        print_counts();
        if (error_count == 0 && u_board_top.u_board_top_properties.fail_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Error: watchdog expired after %0d ns, the tests did not finish",
                 watchdog_ns);
        print_counts();
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: board_top.f
hdl/board_pkg.sv
hdl/slow_tick_gen.sv
hdl/i2s_mic_receiver.sv
hdl/i2s_audio_out.sv
hdl/seven_seg_display.sv
hdl/lab_top.sv
hdl/board_top.sv
verif/board_top_properties.sv
verif/tb_board_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_board_top
FILELIST  := board_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Test OK$$'

clean:
	rm -rf $(OBJ_DIR)
